// ==== all.f ====
rtl/gb_bus_pkg.sv
rtl/gb_periph_pkg.sv
rtl/io_decode.sv
rtl/timer_unit.sv
rtl/interrupt_unit.sv
rtl/read_mux.sv
rtl/io_block_top.sv
tests/tb_clock_gen.sv
tests/tb_io_block.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_io_block
FILELIST = all.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir

// ==== tests/tb_io_block.sv ====
`timescale 1ns/1ps

module tb_io_block
   import gb_bus_pkg::*;
   import gb_periph_pkg::*;
();

   localparam int reset_cycles   = 16;
   localparam int div_wait_max   = 2303;
   localparam int timer_wait_max = 48;
   localparam int test_cycles    = reset_cycles + 20 + 50 + 2 * (div_wait_max + 4)
                                   + (timer_wait_max + 12) + 100 + 24;
   localparam int watchdog_cycles = test_cycles * 12 / 10;

   localparam page_index_t mapped_offsets [6] = '{div_offset, tima_offset, tma_offset,
                                                 tac_offset, if_offset, ie_offset};

   logic        clock_in;
   logic        synch_reset;
   cpu_addr_t   addr;
   byte_t       wr_data;
   logic        we_l;
   logic        re_l;
   byte_t       rd_data;
   page_index_t sw_select;
   byte_t       led_data;
   logic        vblank_req;
   logic        lcdstat_req;
   logic        joypad_req;
   logic        irq;

   // Reference model of the writable registers
   byte_t       model_tma;
   tac_t        model_tac;
   irq_bits_t   model_if;
   irq_bits_t   model_ie;
   irq_bits_t   req_drv;

   // Expected values and their copies one cycle later
   byte_t       exp_lo;
   byte_t       exp_hi;
   byte_t       exp_lo_q;
   byte_t       exp_hi_q;
   logic        exp_irq;
   logic        exp_irq_q;
   logic        rd_check;
   logic        led_check;
   logic        irq_check;
   logic        rd_check_q;
   logic        led_check_q;
   int          error_count;
   int          n;
   int          i;
   byte_t       value;
   irq_bits_t   bits;
   logic        got_flag;

   tb_clock_gen clk0 (.clock_in(clock_in));

   io_block_top dut0 (.*);

   // ======================================================================
   // Response checks
   // ======================================================================

   always @(posedge clock_in) begin
      exp_lo_q    <= exp_lo;
      exp_hi_q    <= exp_hi;
      exp_irq_q   <= exp_irq;
      rd_check_q  <= rd_check && !re_l;
      led_check_q <= led_check;
   end

   read_value: assert property (@(posedge clock_in) disable iff (synch_reset)
      rd_check_q |-> (rd_data >= exp_lo_q && rd_data <= exp_hi_q))
   else begin
      error_count++;
      $display("CHECK FAILED at %0t: read data %02h, expected %02h to %02h",
               $time, $sampled(rd_data), $sampled(exp_lo_q), $sampled(exp_hi_q));
   end

   // LEDs and bus read of the same offset load at the same edge
   led_value: assert property (@(posedge clock_in) disable iff (synch_reset)
      led_check_q |-> (led_data == rd_data))
   else begin
      error_count++;
      $display("CHECK FAILED at %0t: led data %02h differs from read data %02h",
               $time, $sampled(led_data), $sampled(rd_data));
   end

   irq_level: assert property (@(posedge clock_in) disable iff (synch_reset)
      irq_check |-> (irq == exp_irq_q))
   else begin
      error_count++;
      $display("CHECK FAILED at %0t: irq is %0b, expected %0b",
               $time, $sampled(irq), $sampled(exp_irq_q));
   end

   // ======================================================================
   // Bus tasks
   // ======================================================================

   task automatic next_cycle();
      @(posedge clock_in);
      #5;
   endtask

   function automatic cpu_addr_t io_addr(input page_index_t offset);
      return {8'hFF, offset};
   endfunction

   // Expected read range from the model
   // DIV and TIMA only get bounds
   task automatic set_expected(input page_index_t offset);
      case (offset)
         div_offset, tima_offset: exp_lo = 8'h00;
         tma_offset:              exp_lo = model_tma;
         tac_offset:              exp_lo = {5'b11111, model_tac};
         if_offset:               exp_lo = {3'b111, model_if};
         ie_offset:               exp_lo = {3'b000, model_ie};
         default:                 exp_lo = 8'hFF;
      endcase
      exp_hi = (offset == div_offset || offset == tima_offset) ? 8'hFF : exp_lo;
   endtask

   task automatic read_range(input cpu_addr_t address, input byte_t lo, input byte_t hi);
      addr     = address;
      exp_lo   = lo;
      exp_hi   = hi;
      re_l     = 1'b0;
      rd_check = 1'b1;
      next_cycle();
      re_l     = 1'b1;
      rd_check = 1'b0;
   endtask

   task automatic read_model(input page_index_t offset);
      set_expected(offset);
      read_range(io_addr(offset), exp_lo, exp_hi);
   endtask

   task automatic debug_read(input page_index_t offset);
      sw_select = offset;
      led_check = 1'b1;
      read_model(offset);
      led_check = 1'b0;
   endtask

   task automatic write_reg(input page_index_t offset, input byte_t data);
      addr    = io_addr(offset);
      wr_data = data;
      we_l    = 1'b0;
      case (offset)
         tma_offset: model_tma = data;
         tac_offset: model_tac = data[2:0];
         if_offset:  model_if  = data[4:0] | req_drv;
         ie_offset:  model_ie  = data[4:0];
         default: ;
      endcase
      exp_irq = |(model_if & model_ie);
      next_cycle();
      we_l = 1'b1;
   endtask

   task automatic drive_requests(input irq_bits_t req);
      req_drv     = req;
      vblank_req  = req[irq_vblank_bit];
      lcdstat_req = req[irq_lcdstat_bit];
      joypad_req  = req[irq_joypad_bit];
      model_if    = model_if | req;
      exp_irq     = |(model_if & model_ie);
   endtask

   // ======================================================================
   // Stimulus
   // ======================================================================

   initial begin
      void'($urandom(5));
      synch_reset = 1'b1;
      addr        = '0;
      wr_data     = '0;
      we_l        = 1'b1;
      re_l        = 1'b1;
      sw_select   = '0;
      vblank_req  = 1'b0;
      lcdstat_req = 1'b0;
      joypad_req  = 1'b0;
      model_tma   = '0;
      model_tac   = '0;
      model_if    = '0;
      model_ie    = '0;
      req_drv     = '0;
      exp_lo      = '0;
      exp_hi      = '0;
      exp_irq     = 1'b0;
      rd_check    = 1'b0;
      led_check   = 1'b0;
      irq_check   = 1'b0;
      error_count = 0;
      repeat (reset_cycles) @(posedge clock_in);
      #5;
      synch_reset = 1'b0;

      // Reset values
      assert (rd_data == 8'h00 && led_data == 8'h00 && irq == 1'b0) else begin
         error_count++;
         $display("CHECK FAILED at %0t: outputs not cleared by reset", $time);
      end
      read_range(io_addr(tima_offset), 8'h00, 8'h00);
      read_model(tma_offset);
      read_model(tac_offset);
      read_model(if_offset);
      read_model(ie_offset);
      read_model(8'h00);
      read_model(8'h10);
      read_model(8'hFE);
      read_range(16'h1205, 8'hFF, 8'hFF);
      read_range(16'hC0FF, 8'hFF, 8'hFF);

      // Register write and read back
      for (i = 0; i < 8; i++) begin
         write_reg(tma_offset, byte_t'($urandom));
         read_model(tma_offset);
         write_reg(tac_offset, byte_t'($urandom));
         read_model(tac_offset);
         write_reg(ie_offset, byte_t'($urandom));
         read_model(ie_offset);
      end

      // Divider restart and count
      for (i = 0; i < 2; i++) begin
         n = 256 + int'($urandom % 2048);
         write_reg(div_offset, byte_t'($urandom));
         repeat (n) next_cycle();
         read_range(io_addr(div_offset), byte_t'(n / 256 - 1), byte_t'(n / 256 + 1));
      end

      // Timer overflow watched on the LEDs
      write_reg(tac_offset, 8'h00);
      repeat (3) next_cycle();
      write_reg(if_offset, 8'h00);
      sw_select = if_offset;
      write_reg(tma_offset, byte_t'($urandom));
      write_reg(tima_offset, 8'hFE);
      write_reg(tac_offset, 8'h05);
      got_flag = 1'b0;
      for (i = 0; i < timer_wait_max && !got_flag; i++) begin
         next_cycle();
         got_flag = led_data[irq_timer_bit];
      end
      assert (got_flag) else begin
         error_count++;
         $display("Timer overflow did not set IF bit 2 within %0d cycles", timer_wait_max);
      end
      model_if[irq_timer_bit] = 1'b1;
      read_range(io_addr(tima_offset), model_tma, 8'hFF);

      // Request pulses and the pending level
      write_reg(tac_offset, 8'h00);
      repeat (3) next_cycle();
      write_reg(if_offset, 8'h00);
      write_reg(ie_offset, 8'h13);
      irq_check = 1'b1;
      for (i = 0; i < 16; i++) begin
         bits = irq_bits_t'($urandom) & 5'h13;
         drive_requests(bits);
         if (i == 8) begin
            write_reg(if_offset, byte_t'($urandom));
         end else begin
            next_cycle();
         end
         drive_requests('0);
         if (i % 4 == 3) begin
            write_reg(ie_offset, byte_t'($urandom));
         end
         read_model(if_offset);
      end
      write_reg(if_offset, 8'h00);
      repeat (2) next_cycle();
      assert (irq == 1'b0) else begin
         error_count++;
         $display("CHECK FAILED at %0t: irq still high after IF cleared", $time);
      end
      irq_check = 1'b0;

      // Debug view over mapped and random offsets
      for (i = 0; i < 16; i++) begin
         value = (i % 4 == 0) ? byte_t'($urandom) : mapped_offsets[$urandom % 6];
         debug_read(value);
      end

      repeat (2) next_cycle();
      $display("Run finished with %0d errors", error_count);
      if (error_count == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

   // Watchdog
   initial begin
      repeat (watchdog_cycles) @(posedge clock_in);
      $display("Run timed out after %0d cycles", watchdog_cycles);
      $display("TESTS FAILED");
      $finish;
   end

endmodule

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
   output logic clock_in
);

   // Half of the 40 ns period
   localparam int half_period = 20;

   initial begin
      clock_in = 1'b0;
   end

   always begin
      #(half_period);
      clock_in = ~clock_in;
   end

endmodule

// ==== rtl/io_block_top.sv ====
`timescale 1ns/1ps

module io_block_top
   import gb_bus_pkg::*;
   import gb_periph_pkg::*;
(
   input  logic        clock_in,
   input  logic        synch_reset,
   input  cpu_addr_t   addr,
   input  byte_t       wr_data,
   input  logic        we_l,
   input  logic        re_l,
   output byte_t       rd_data,
   input  page_index_t sw_select,
   output byte_t       led_data,
   input  logic        vblank_req,
   input  logic        lcdstat_req,
   input  logic        joypad_req,
   output logic        irq
);

   reg_id_t   bus_reg;
   reg_id_t   dbg_reg;
   logic      wr_div;
   logic      wr_tima;
   logic      wr_tma;
   logic      wr_tac;
   logic      wr_if;
   logic      wr_ie;
   byte_t     div_value;
   byte_t     tima_value;
   byte_t     tma_value;
   tac_t      tac_value;
   logic      timer_req;
   irq_bits_t if_value;
   irq_bits_t ie_value;

   // ======================================================================
   // Decode
   // ======================================================================

   io_decode decode0 (
      .addr      (addr),
      .sw_select (sw_select),
      .we_l      (we_l),
      .re_l      (re_l),
      .bus_reg   (bus_reg),
      .dbg_reg   (dbg_reg),
      .wr_div    (wr_div),
      .wr_tima   (wr_tima),
      .wr_tma    (wr_tma),
      .wr_tac    (wr_tac),
      .wr_if     (wr_if),
      .wr_ie     (wr_ie)
   );

   // ======================================================================
   // Timer and interrupts
   // ======================================================================

   timer_unit timer0 (
      .clock_in    (clock_in),
      .synch_reset (synch_reset),
      .wr_data     (wr_data),
      .wr_div      (wr_div),
      .wr_tima     (wr_tima),
      .wr_tma      (wr_tma),
      .wr_tac      (wr_tac),
      .div_value   (div_value),
      .tima_value  (tima_value),
      .tma_value   (tma_value),
      .tac_value   (tac_value),
      .timer_req   (timer_req)
   );

   interrupt_unit intr0 (
      .clock_in    (clock_in),
      .synch_reset (synch_reset),
      .wr_data     (wr_data),
      .wr_if       (wr_if),
      .wr_ie       (wr_ie),
      .vblank_req  (vblank_req),
      .lcdstat_req (lcdstat_req),
      .joypad_req  (joypad_req),
      .timer_req   (timer_req),
      .if_value    (if_value),
      .ie_value    (ie_value),
      .irq         (irq)
   );

   // Bus and LED readback
   read_mux read0 (
      .clock_in    (clock_in),
      .synch_reset (synch_reset),
      .re_l        (re_l),
      .bus_reg     (bus_reg),
      .dbg_reg     (dbg_reg),
      .div_value   (div_value),
      .tima_value  (tima_value),
      .tma_value   (tma_value),
      .tac_value   (tac_value),
      .if_value    (if_value),
      .ie_value    (ie_value),
      .rd_data     (rd_data),
      .led_data    (led_data)
   );

endmodule

// ==== rtl/read_mux.sv ====
`timescale 1ns/1ps

module read_mux
   import gb_bus_pkg::*;
   import gb_periph_pkg::*;
(
   input  logic      clock_in,
   input  logic      synch_reset,
   input  logic      re_l,
   input  reg_id_t   bus_reg,
   input  reg_id_t   dbg_reg,
   input  byte_t     div_value,
   input  byte_t     tima_value,
   input  byte_t     tma_value,
   input  tac_t      tac_value,
   input  irq_bits_t if_value,
   input  irq_bits_t ie_value,
   output byte_t     rd_data,
   output byte_t     led_data
);

   // Readable byte of one register, with fill bits
   function automatic byte_t reg_byte(input reg_id_t id);
      byte_t value;
      case (id)
         reg_div:  value = div_value;
         reg_tima: value = tima_value;
         reg_tma:  value = tma_value;
         reg_tac:  value = tac_fill | byte_t'(tac_value);
         reg_if:   value = if_fill | byte_t'(if_value);
         reg_ie:   value = ie_fill | byte_t'(ie_value);
         default:  value = open_bus_value;
      endcase
      return value;
   endfunction

   // ======================================================================
   // Output registers
   // ======================================================================

   always_ff @(posedge clock_in) begin
      if (synch_reset) begin
         rd_data  <= '0;
         led_data <= '0;
      end else begin
         // Bus data holds between reads
         if (!re_l) begin
            rd_data <= reg_byte(bus_reg);
         end
         // LEDs follow the switches every cycle
         led_data <= reg_byte(dbg_reg);
      end
   end

endmodule

// ==== rtl/interrupt_unit.sv ====
`timescale 1ns/1ps

module interrupt_unit
   import gb_bus_pkg::*;
   import gb_periph_pkg::*;
(
   input  logic      clock_in,
   input  logic      synch_reset,
   input  byte_t     wr_data,
   input  logic      wr_if,
   input  logic      wr_ie,
   input  logic      vblank_req,
   input  logic      lcdstat_req,
   input  logic      joypad_req,
   input  logic      timer_req,
   output irq_bits_t if_value,
   output irq_bits_t ie_value,
   output logic      irq
);

   irq_bits_t req_bits;
   irq_bits_t if_q;
   irq_bits_t ie_q;

   // Gather request pulses, serial bit stays low
   always_comb begin
      req_bits                  = '0;
      req_bits[irq_vblank_bit]  = vblank_req;
      req_bits[irq_lcdstat_bit] = lcdstat_req;
      req_bits[irq_timer_bit]   = timer_req;
      req_bits[irq_joypad_bit]  = joypad_req;
   end

   // ======================================================================
   // Flag and enable registers
   // ======================================================================

   always_ff @(posedge clock_in) begin
      if (synch_reset) begin
         if_q <= '0;
         ie_q <= '0;
      end else begin
         // A request in the same cycle as a CPU write is not lost
         if (wr_if) begin
            if_q <= wr_data[irq_width-1:0] | req_bits;
         end else begin
            if_q <= if_q | req_bits;
         end
         if (wr_ie) begin
            ie_q <= wr_data[irq_width-1:0];
         end
      end
   end

   assign irq      = |(if_q & ie_q);
   assign if_value = if_q;
   assign ie_value = ie_q;

endmodule

// ==== rtl/timer_unit.sv ====
`timescale 1ns/1ps

module timer_unit
   import gb_bus_pkg::*;
   import gb_periph_pkg::*;
(
   input  logic  clock_in,
   input  logic  synch_reset,
   input  byte_t wr_data,
   input  logic  wr_div,
   input  logic  wr_tima,
   input  logic  wr_tma,
   input  logic  wr_tac,
   output byte_t div_value,
   output byte_t tima_value,
   output byte_t tma_value,
   output tac_t  tac_value,
   output logic  timer_req
);

   div_count_t div_count;
   div_count_t tick_mask;
   byte_t      tima_q;
   byte_t      tma_q;
   tac_t       tac_q;
   logic       tick;
   logic       overflow;

   // ======================================================================
   // Divider
   // ======================================================================

   // Any write to DIV restarts the whole count
   always_ff @(posedge clock_in) begin
      if (synch_reset || wr_div) begin
         div_count <= '0;
      end else begin
         div_count <= div_count + 1'b1;
      end
   end

   // ======================================================================
   // Timer counter
   // ======================================================================

   // Rate select
   always_comb begin
      case (tac_q[1:0])
         2'b00:   tick_mask = rate_mask_1024;
         2'b01:   tick_mask = rate_mask_16;
         2'b10:   tick_mask = rate_mask_64;
         default: tick_mask = rate_mask_256;
      endcase
   end

   assign tick = tac_q[tac_enable_bit] && ((div_count & tick_mask) == tick_mask);

   // A CPU write to TIMA cancels the overflow
   assign overflow = tick && (tima_q == 8'hFF) && !wr_tima;

   always_ff @(posedge clock_in) begin
      if (synch_reset) begin
         tima_q    <= '0;
         tma_q     <= '0;
         tac_q     <= '0;
         timer_req <= 1'b0;
      end else begin
         timer_req <= overflow;
         if (wr_tima) begin
            tima_q <= wr_data;
         end else if (overflow) begin
            // Reload from modulo
            tima_q <= tma_q;
         end else if (tick) begin
            tima_q <= tima_q + 1'b1;
         end
         if (wr_tma) begin
            tma_q <= wr_data;
         end
         if (wr_tac) begin
            tac_q <= wr_data[tac_width-1:0];
         end
      end
   end

   assign div_value  = div_count[div_width-1 -: data_width];
   assign tima_value = tima_q;
   assign tma_value  = tma_q;
   assign tac_value  = tac_q;

endmodule

// ==== rtl/io_decode.sv ====
`timescale 1ns/1ps

module io_decode
   import gb_bus_pkg::*;
   import gb_periph_pkg::*;
(
   input  cpu_addr_t   addr,
   input  page_index_t sw_select,
   input  logic        we_l,
   input  logic        re_l,
   output reg_id_t     bus_reg,
   output reg_id_t     dbg_reg,
   output logic        wr_div,
   output logic        wr_tima,
   output logic        wr_tma,
   output logic        wr_tac,
   output logic        wr_if,
   output logic        wr_ie
);

   logic in_page;
   logic bus_access;

   // Page offset to register
   function automatic reg_id_t offset_to_reg(input page_index_t offset);
      reg_id_t id;
      case (offset)
         div_offset:  id = reg_div;
         tima_offset: id = reg_tima;
         tma_offset:  id = reg_tma;
         tac_offset:  id = reg_tac;
         if_offset:   id = reg_if;
         ie_offset:   id = reg_ie;
         default:     id = reg_none;
      endcase
      return id;
   endfunction

   assign in_page    = (addr[addr_width-1:8] == io_page_base[addr_width-1:8]);
   assign bus_access = !we_l || !re_l;

   // Bus side only decodes during a strobe
   assign bus_reg = (in_page && bus_access) ? offset_to_reg(addr[7:0]) : reg_none;

   // Debug side indexes the page directly
   assign dbg_reg = offset_to_reg(sw_select);

   // ======================================================================
   // Write strobes
   // ======================================================================

   assign wr_div  = !we_l && (bus_reg == reg_div);
   assign wr_tima = !we_l && (bus_reg == reg_tima);
   assign wr_tma  = !we_l && (bus_reg == reg_tma);
   assign wr_tac  = !we_l && (bus_reg == reg_tac);
   assign wr_if   = !we_l && (bus_reg == reg_if);
   assign wr_ie   = !we_l && (bus_reg == reg_ie);

endmodule

// ==== rtl/gb_periph_pkg.sv ====
package gb_periph_pkg;

   // ======================================================================
   // Timer state
   // ======================================================================

   localparam int div_width = 16;
   localparam int tac_width = 3;

   // Internal divider, DIV is the upper byte
   typedef logic [div_width-1:0] div_count_t;

   // Bit 2 enable, bits 1:0 rate select
   typedef logic [tac_width-1:0] tac_t;
   localparam int tac_enable_bit = 2;

   // Low divider bits that are all ones once per timer period
   localparam div_count_t rate_mask_1024 = 16'h03FF;
   localparam div_count_t rate_mask_16   = 16'h000F;
   localparam div_count_t rate_mask_64   = 16'h003F;
   localparam div_count_t rate_mask_256  = 16'h00FF;

   // ======================================================================
   // Interrupts
   // ======================================================================

   localparam int irq_width = 5;
   typedef logic [irq_width-1:0] irq_bits_t;

   // Bit 3 is the serial request, not implemented here
   localparam int irq_vblank_bit  = 0;
   localparam int irq_lcdstat_bit = 1;
   localparam int irq_timer_bit   = 2;
   localparam int irq_joypad_bit  = 4;

   // Unused upper bits as seen on a read
   localparam logic [7:0] tac_fill = 8'hF8;
   localparam logic [7:0] if_fill  = 8'hE0;
   localparam logic [7:0] ie_fill  = 8'h00;

endpackage

// ==== rtl/gb_bus_pkg.sv ====
package gb_bus_pkg;

   // ======================================================================
   // CPU side byte bus
   // ======================================================================

   localparam int addr_width = 16;
   localparam int data_width = 8;

   typedef logic [addr_width-1:0] cpu_addr_t;
   typedef logic [data_width-1:0] byte_t;

   // Low byte of an address inside the FFxx page
   typedef logic [7:0] page_index_t;

   // Upper byte of this constant marks the I/O page
   localparam cpu_addr_t io_page_base = 16'hFF00;

   // ======================================================================
   // Register map, as offsets into the I/O page
   // ======================================================================

   localparam page_index_t div_offset  = 8'h04;
   localparam page_index_t tima_offset = 8'h05;
   localparam page_index_t tma_offset  = 8'h06;
   localparam page_index_t tac_offset  = 8'h07;
   localparam page_index_t if_offset   = 8'h0F;
   localparam page_index_t ie_offset   = 8'hFF;

   // Unmapped reads float high
   localparam byte_t open_bus_value = 8'hFF;

   typedef enum logic [2:0] {
      reg_none,
      reg_div,
      reg_tima,
      reg_tma,
      reg_tac,
      reg_if,
      reg_ie
   } reg_id_t;

endpackage
